/* hw/mipsSettings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// ********************
// core dimensions
// ********************

`define DATA_WIDTH 32

`define IMEM_DEPTH 256

`define DMEM_DEPTH 256

`define REG_COUNT 32

`endif

/* hw/mipsPkg.sv */
`include "mipsSettings.svh"

package mipsPkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIndex_t;
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [1:0] aluOp_t;
    typedef logic [3:0] aluFunc_t;
    typedef logic [$clog2(`IMEM_DEPTH)-1:0] imemIndex_t;

    // ********************
    // instruction encodings
    // ********************
    localparam opcode_t opRType = 6'h00;
    localparam opcode_t opLw = 6'h23;
    localparam opcode_t opSw = 6'h2b;
    localparam opcode_t opBeq = 6'h04;
    localparam opcode_t opJ = 6'h02;
    localparam opcode_t opAddi = 6'h08;

    localparam funct_t functAdd = 6'h20;
    localparam funct_t functSub = 6'h22;
    localparam funct_t functAnd = 6'h24;
    localparam funct_t functOr = 6'h25;
    localparam funct_t functSlt = 6'h2a;

    localparam aluOp_t aluOpAdd = 2'b00; // memory address and addi.
    localparam aluOp_t aluOpSub = 2'b01; // beq compare.
    localparam aluOp_t aluOpFunct = 2'b10; // R-type, decided by funct.

    localparam aluFunc_t aluAnd = 4'b0000;
    localparam aluFunc_t aluOr = 4'b0001;
    localparam aluFunc_t aluAdd = 4'b0010;
    localparam aluFunc_t aluSub = 4'b0110;
    localparam aluFunc_t aluSlt = 4'b0111;

endpackage

/* hw/FetchUnit.sv */
`timescale 1ns/10ps
`include "mipsSettings.svh"

module FetchUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  logic                 programWrite,
    input  mipsPkg::imemIndex_t  programAddress,
    input  mipsPkg::word_t       programData,
    input  logic                 branch,
    input  logic                 zero,
    input  logic                 jump,
    output mipsPkg::word_t       instruction,
    output mipsPkg::word_t       pc,
    output mipsPkg::word_t       incrementedPc
);

    localparam int IndexWidth = $bits(mipsPkg::imemIndex_t);

    mipsPkg::word_t imem [`IMEM_DEPTH];
    mipsPkg::imemIndex_t pcIndex;
    mipsPkg::word_t branchOffset;
    mipsPkg::word_t branchTarget;
    mipsPkg::word_t jumpTarget;
    mipsPkg::word_t nextPc;

    // ********************
    // instruction memory
    // ********************

    always_ff @(posedge clk) begin
        if (programWrite) begin
            imem[programAddress] <= programData; // loaded while the core is stopped.
        end
    end

    assign pcIndex = pc[IndexWidth+1:2]; // word address.
    assign instruction = imem[pcIndex];

    // ********************
    // next pc
    // ********************

    assign incrementedPc = pc + 32'd4;
    assign branchOffset = {{14{instruction[15]}}, instruction[15:0], 2'b00};
    assign branchTarget = incrementedPc + branchOffset;
    assign jumpTarget = {incrementedPc[31:28], instruction[25:0], 2'b00};

    always_comb begin
        if (jump) begin
            nextPc = jumpTarget;
        end else if (branch && zero) begin
            nextPc = branchTarget;
        end else begin
            nextPc = incrementedPc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc; // frozen while run is low.
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc lost word alignment");

endmodule

/* hw/ControlUnit.sv */
`timescale 1ns/10ps

module ControlUnit (
    input  mipsPkg::word_t   instruction,
    input  logic             run,
    output logic             regDst,
    output logic             jump,
    output logic             branch,
    output logic             memWrite,
    output logic             memToReg,
    output mipsPkg::aluOp_t  aluOp,
    output logic             aluSource,
    output logic             regWrite
);

    mipsPkg::opcode_t opcode;
    logic decodedMemWrite;
    logic decodedRegWrite;

    assign opcode = instruction[31:26];

    always_comb begin
        regDst = 1'b0;
        jump = 1'b0;
        branch = 1'b0;
        decodedMemWrite = 1'b0;
        memToReg = 1'b0;
        aluOp = mipsPkg::aluOpAdd;
        aluSource = 1'b0;
        decodedRegWrite = 1'b0;
        case (opcode)
            mipsPkg::opRType: begin
                regDst = 1'b1; // destination is rd.
                aluOp = mipsPkg::aluOpFunct;
                decodedRegWrite = 1'b1;
            end
            mipsPkg::opLw: begin
                aluSource = 1'b1;
                memToReg = 1'b1;
                decodedRegWrite = 1'b1;
            end
            mipsPkg::opSw: begin
                aluSource = 1'b1;
                decodedMemWrite = 1'b1;
            end
            mipsPkg::opBeq: begin
                branch = 1'b1;
                aluOp = mipsPkg::aluOpSub; // zero flag compares rs and rt.
            end
            mipsPkg::opJ: begin
                jump = 1'b1;
            end
            mipsPkg::opAddi: begin
                aluSource = 1'b1;
                decodedRegWrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign memWrite = decodedMemWrite && run; // nothing is written while stopped.
    assign regWrite = decodedRegWrite && run;

    jumpBranchExclusive: assert #0 (!(jump && branch))
        else $error("jump and branch decoded together");

endmodule

/* hw/AluControl.sv */
`timescale 1ns/10ps

module AluControl (
    input  mipsPkg::aluOp_t    aluOp,
    input  mipsPkg::word_t     instruction,
    output mipsPkg::aluFunc_t  aluFunc
);

    mipsPkg::funct_t funct;

    assign funct = instruction[5:0];

    always_comb begin
        case (aluOp)
            mipsPkg::aluOpSub: begin
                aluFunc = mipsPkg::aluSub;
            end
            mipsPkg::aluOpFunct: begin
                case (funct)
                    mipsPkg::functAdd: aluFunc = mipsPkg::aluAdd;
                    mipsPkg::functSub: aluFunc = mipsPkg::aluSub;
                    mipsPkg::functAnd: aluFunc = mipsPkg::aluAnd;
                    mipsPkg::functOr: aluFunc = mipsPkg::aluOr;
                    mipsPkg::functSlt: aluFunc = mipsPkg::aluSlt;
                    default: aluFunc = mipsPkg::aluAdd; // other funct codes add.
                endcase
            end
            default: begin
                aluFunc = mipsPkg::aluAdd; // address and addi.
            end
        endcase
    end

endmodule

/* hw/Alu.sv */
`timescale 1ns/10ps

module Alu (
    input  mipsPkg::word_t     readData1,
    input  mipsPkg::word_t     readData2,
    input  mipsPkg::word_t     instruction,
    input  logic               aluSource,
    input  mipsPkg::aluFunc_t  aluFunc,
    output mipsPkg::word_t     aluResult,
    output logic               zero
);

    mipsPkg::word_t signExtended;
    mipsPkg::word_t operand2;

    assign signExtended = {{16{instruction[15]}}, instruction[15:0]};
    assign operand2 = aluSource ? signExtended : readData2;

    always_comb begin
        case (aluFunc)
            mipsPkg::aluAnd: aluResult = readData1 & operand2;
            mipsPkg::aluOr: aluResult = readData1 | operand2;
            mipsPkg::aluSub: aluResult = readData1 - operand2;
            mipsPkg::aluSlt: begin
                aluResult = '0;
                aluResult[0] = $signed(readData1) < $signed(operand2); // signed compare.
            end
            default: aluResult = readData1 + operand2;
        endcase
    end

    assign zero = (aluResult == '0);

endmodule

/* hw/Registers.sv */
`timescale 1ns/10ps
`include "mipsSettings.svh"

module Registers (
    input  logic                clk,
    input  logic                reset,
    input  mipsPkg::word_t      instruction,
    input  logic                regDst,
    input  logic                regWrite,
    input  logic                memToReg,
    input  mipsPkg::word_t      aluResult,
    input  mipsPkg::word_t      readDataMem,
    output mipsPkg::word_t      readData1,
    output mipsPkg::word_t      readData2,
    output mipsPkg::regIndex_t  writeIndex,
    output mipsPkg::word_t      writeData
);

    mipsPkg::word_t regs [`REG_COUNT];
    mipsPkg::regIndex_t rs;
    mipsPkg::regIndex_t rt;
    mipsPkg::regIndex_t rd;

    assign rs = instruction[25:21];
    assign rt = instruction[20:16];
    assign rd = instruction[15:11];

    assign readData1 = regs[rs];
    assign readData2 = regs[rt];

    // ********************
    // write back
    // ********************

    assign writeIndex = regDst ? rd : rt;
    assign writeData = memToReg ? readDataMem : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && writeIndex != '0) begin
            regs[writeIndex] <= writeData; // register 0 is never written.
        end
    end

    zeroRegister: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("register 0 holds a nonzero value");

endmodule

/* hw/DataMemory.sv */
`timescale 1ns/10ps
`include "mipsSettings.svh"

module DataMemory (
    input  logic            clk,
    input  logic            reset,
    input  logic            memWrite,
    input  mipsPkg::word_t  address,
    input  mipsPkg::word_t  writeData,
    output mipsPkg::word_t  readData
);

    localparam int IndexWidth = $clog2(`DMEM_DEPTH);

    mipsPkg::word_t mem [`DMEM_DEPTH];
    logic [IndexWidth-1:0] wordIndex;

    assign wordIndex = address[IndexWidth+1:2]; // byte address to word.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (memWrite) begin
            mem[wordIndex] <= writeData;
        end
    end

    assign readData = mem[wordIndex];

endmodule

/* hw/MIPS.sv */
`timescale 1ns/10ps

module MIPS (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 programWrite,
    input  mipsPkg::imemIndex_t  programAddress,
    input  mipsPkg::word_t       programData,
    input  logic                 run,
    output mipsPkg::word_t       pc,
    output logic                 traceRegWrite,
    output mipsPkg::regIndex_t   traceRegIndex,
    output mipsPkg::word_t       traceRegData,
    output logic                 traceMemWrite,
    output mipsPkg::word_t       traceMemAddress,
    output mipsPkg::word_t       traceMemData
);

    // ********************
    // control signals
    // ********************
    logic regDst;
    logic jump;
    logic branch;
    logic memWrite;
    logic memToReg;
    mipsPkg::aluOp_t aluOp;
    logic aluSource;
    logic regWrite;
    logic zero;
    mipsPkg::aluFunc_t aluFunc;

    // ********************
    // data signals
    // ********************
    mipsPkg::word_t instruction;
    mipsPkg::word_t readData1;
    mipsPkg::word_t readData2;
    mipsPkg::word_t aluResult;
    mipsPkg::word_t readDataMem;
    mipsPkg::regIndex_t writeIndex;
    mipsPkg::word_t writeData;

    FetchUnit fetchUnit (
        .clk(clk),
        .reset(reset),
        .run(run),
        .programWrite(programWrite),
        .programAddress(programAddress),
        .programData(programData),
        .branch(branch),
        .zero(zero),
        .jump(jump),
        .instruction(instruction),
        .pc(pc),
        .incrementedPc()
    );

    ControlUnit control (
        .instruction(instruction),
        .run(run),
        .regDst(regDst),
        .jump(jump),
        .branch(branch),
        .memWrite(memWrite),
        .memToReg(memToReg),
        .aluOp(aluOp),
        .aluSource(aluSource),
        .regWrite(regWrite)
    );

    AluControl aluControl (
        .aluOp(aluOp),
        .instruction(instruction),
        .aluFunc(aluFunc)
    );

    Alu alu (
        .readData1(readData1),
        .readData2(readData2),
        .instruction(instruction),
        .aluSource(aluSource),
        .aluFunc(aluFunc),
        .aluResult(aluResult),
        .zero(zero)
    );

    Registers registers (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .regDst(regDst),
        .regWrite(regWrite),
        .memToReg(memToReg),
        .aluResult(aluResult),
        .readDataMem(readDataMem),
        .readData1(readData1),
        .readData2(readData2),
        .writeIndex(writeIndex),
        .writeData(writeData)
    );

    DataMemory dataMemory (
        .clk(clk),
        .reset(reset),
        .memWrite(memWrite),
        .address(aluResult),
        .writeData(readData2),
        .readData(readDataMem)
    );

    assign traceRegWrite = regWrite && (writeIndex != '0); // register 0 writes are dropped.
    assign traceRegIndex = writeIndex;
    assign traceRegData = writeData;
    assign traceMemWrite = memWrite;
    assign traceMemAddress = aluResult;
    assign traceMemData = readData2;

endmodule

/* test/MIPS_tb.sv */
`timescale 1ns/10ps
`include "mipsSettings.svh"

module MIPS_tb;

    localparam int programWords = 64;
    localparam int programCount = 3;
    localparam int freezeCycles = 3;
    localparam int timeoutCycles = 3 * (programWords + programWords) + 20;

    logic clk;
    logic reset;
    logic run;
    logic programWrite;
    mipsPkg::imemIndex_t programAddress;
    mipsPkg::word_t programData;
    mipsPkg::word_t pc;
    logic traceRegWrite;
    mipsPkg::regIndex_t traceRegIndex;
    mipsPkg::word_t traceRegData;
    logic traceMemWrite;
    mipsPkg::word_t traceMemAddress;
    mipsPkg::word_t traceMemData;

    mipsPkg::word_t programImage [programWords];
    mipsPkg::word_t modelRegs [`REG_COUNT];
    mipsPkg::word_t modelMem [`DMEM_DEPTH];
    mipsPkg::word_t modelPc;
    logic [31:0] lfsrState;
    int cycleCount = 0;

    MIPS uut (
        .clk(clk),
        .reset(reset),
        .programWrite(programWrite),
        .programAddress(programAddress),
        .programData(programData),
        .run(run),
        .pc(pc),
        .traceRegWrite(traceRegWrite),
        .traceRegIndex(traceRegIndex),
        .traceRegData(traceRegData),
        .traceMemWrite(traceMemWrite),
        .traceMemAddress(traceMemAddress),
        .traceMemData(traceMemData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            $display("timeout after %0d cycles, the core never finished the test", cycleCount);
            $display("Finished with errors");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s expected %h actual %h", testName, expected, actual);
            $display("Finished with errors");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // ********************
    // stimulus
    // ********************

    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // taps 32 22 2 1.
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] result;
        result = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = nextLfsr(lfsrState);
            result = {result[30:0], lfsrState[31]};
        end
        return result;
    endfunction

    function automatic mipsPkg::word_t encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input mipsPkg::funct_t funct);
        return {mipsPkg::opRType, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic mipsPkg::word_t encodeI(input mipsPkg::opcode_t op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mipsPkg::word_t encodeJ(input logic [25:0] target);
        return {mipsPkg::opJ, target};
    endfunction

    function automatic mipsPkg::funct_t pickFunct(input logic [2:0] choice);
        case (choice)
            3'd0: return mipsPkg::functAdd;
            3'd1: return mipsPkg::functSub;
            3'd2: return mipsPkg::functAnd;
            3'd3: return mipsPkg::functOr;
            3'd5: return mipsPkg::functSub;
            3'd6: return mipsPkg::functAdd;
            default: return mipsPkg::functSlt;
        endcase
    endfunction

    task automatic generateProgram;
        logic [2:0] kind;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        int span;
        for (int i = 0; i < programWords - 1; i++) begin
            kind = 3'(randomBits(3));
            rs = 5'(randomBits(3)); // a few registers only, so operands collide often.
            rt = 5'(randomBits(3));
            rd = 5'(randomBits(3));
            case (kind)
                3'd3: programImage[i] = encodeI(mipsPkg::opAddi, rs, rt, 16'(randomBits(16)));
                3'd4: programImage[i] = encodeI(mipsPkg::opLw, 5'd0, rt, 16'(randomBits(4) << 2));
                3'd5: programImage[i] = encodeI(mipsPkg::opSw, 5'd0, rt, 16'(randomBits(4) << 2));
                3'd6: begin
                    span = int'(randomBits(2));
                    if (span > programWords - 2 - i) begin
                        span = programWords - 2 - i; // stay inside the program.
                    end
                    programImage[i] = encodeI(mipsPkg::opBeq, rs, rt, 16'(span));
                end
                3'd7: begin
                    span = i + 1 + int'(randomBits(3));
                    if (span > programWords - 1) begin
                        span = programWords - 1;
                    end
                    programImage[i] = encodeJ(26'(span));
                end
                default: programImage[i] = encodeR(rs, rt, rd, pickFunct(3'(randomBits(3))));
            endcase
        end
        programImage[programWords - 1] = encodeJ(26'(programWords - 1)); // parks the core.
    endtask

    // ********************
    // reference model
    // ********************

    task automatic stepModel(input int step);
        mipsPkg::word_t instr;
        mipsPkg::word_t a;
        mipsPkg::word_t b;
        mipsPkg::word_t imm;
        mipsPkg::word_t pcPlus4;
        mipsPkg::word_t nextPc;
        mipsPkg::word_t expData;
        mipsPkg::word_t expAddress;
        logic [4:0] expIndex;
        logic expRegWrite;
        logic expMemWrite;
        instr = programImage[modelPc[7:2]];
        a = modelRegs[instr[25:21]];
        b = modelRegs[instr[20:16]];
        imm = {{16{instr[15]}}, instr[15:0]};
        pcPlus4 = modelPc + 32'd4;
        nextPc = pcPlus4;
        expRegWrite = 1'b0;
        expMemWrite = 1'b0;
        expIndex = instr[20:16];
        expData = '0;
        expAddress = a + imm;
        case (instr[31:26])
            mipsPkg::opRType: begin
                expRegWrite = 1'b1;
                expIndex = instr[15:11];
                case (instr[5:0])
                    mipsPkg::functSub: expData = a - b;
                    mipsPkg::functAnd: expData = a & b;
                    mipsPkg::functOr: expData = a | b;
                    mipsPkg::functSlt: expData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: expData = a + b;
                endcase
            end
            mipsPkg::opAddi: begin
                expRegWrite = 1'b1;
                expData = a + imm;
            end
            mipsPkg::opLw: begin
                expRegWrite = 1'b1;
                expData = modelMem[expAddress[9:2]];
            end
            mipsPkg::opSw: expMemWrite = 1'b1;
            mipsPkg::opBeq: begin
                if (a == b) begin
                    nextPc = pcPlus4 + {imm[29:0], 2'b00};
                end
            end
            mipsPkg::opJ: nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
            default: begin
            end
        endcase
        if (expIndex == 5'd0) begin
            expRegWrite = 1'b0; // register 0 is not traced.
        end
        checkValue($sformatf("step %0d pc", step), modelPc, pc);
        checkValue($sformatf("step %0d regWrite", step), 32'(expRegWrite), 32'(traceRegWrite));
        if (expRegWrite) begin
            checkValue($sformatf("step %0d regIndex", step), 32'(expIndex), 32'(traceRegIndex));
            checkValue($sformatf("step %0d regData", step), expData, traceRegData);
            modelRegs[expIndex] = expData;
        end
        checkValue($sformatf("step %0d memWrite", step), 32'(expMemWrite), 32'(traceMemWrite));
        if (expMemWrite) begin
            checkValue($sformatf("step %0d memAddress", step), expAddress, traceMemAddress);
            checkValue($sformatf("step %0d memData", step), b, traceMemData);
            modelMem[expAddress[9:2]] = b;
        end
        modelPc = nextPc;
    endtask

    task automatic loadProgram;
        for (int i = 0; i < `REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            modelMem[i] = '0;
        end
        modelPc = '0;
        for (int i = 0; i < programWords; i++) begin
            @(negedge clk);
            reset = (i < 4); // reset overlaps the first load cycles.
            run = 1'b0;
            programWrite = 1'b1;
            programAddress = 8'(i);
            programData = programImage[i];
            #10;
            if (i >= 4) begin
                checkValue("load pc", 32'd0, pc);
                checkValue("load regWrite", 32'd0, 32'(traceRegWrite));
                checkValue("load memWrite", 32'd0, 32'(traceMemWrite));
            end
        end
    endtask

    task automatic runProgram(input int freezeAt);
        for (int step = 0; step < programWords; step++) begin
            if (step == freezeAt) begin
                for (int f = 0; f < freezeCycles; f++) begin
                    @(negedge clk);
                    programWrite = 1'b0;
                    run = 1'b0;
                    #10;
                    checkValue("frozen pc", modelPc, pc);
                    checkValue("frozen regWrite", 32'd0, 32'(traceRegWrite));
                    checkValue("frozen memWrite", 32'd0, 32'(traceMemWrite));
                end
            end
            @(negedge clk);
            programWrite = 1'b0;
            run = 1'b1;
            #10;
            stepModel(step);
        end
        @(negedge clk);
        #10;
        checkValue("final self-jump pc", 32'((programWords - 1) * 4), pc);
    endtask

    initial begin
        lfsrState = 32'hf09c_c3a7;
        reset = 1'b1;
        run = 1'b0;
        programWrite = 1'b0;
        programAddress = '0;
        programData = '0;
        for (int p = 0; p < programCount; p++) begin
            generateProgram();
            loadProgram();
            runProgram((p == 1) ? 20 : -1); // the second program is paused midway.
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* MIPS.f */
+incdir+hw
hw/mipsPkg.sv
hw/FetchUnit.sv
hw/ControlUnit.sv
hw/AluControl.sv
hw/Alu.sv
hw/Registers.sv
hw/DataMemory.sv
hw/MIPS.sv
test/MIPS_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the MIPS testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f MIPS.f --top-module MIPS_tb \
    -Mdir obj_dir -o MIPS_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/MIPS_sim > sim.log 2>&1
cat sim.log

grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
